// ==== testbench/audio_stim.txt ====
// section: bypass flag and pair count, then coefficients of taps 0 to 7 (q1.15),
// then left and right sample of each pair (24 bit); all hex, ff closes the file
// bypass on, pairs pass straight through
1 3
4000 0000 0000 0000 0000 0000 0000 0000
123456 abcdef
7fffff 800000
000001 fffffe
// impulse on the left reads the coefficients back in order
0 8
4000 2000 1000 0800 c000 e000 0100 ffff
008000 000000
000000 000000  000000 000000
000000 000000  000000 000000
000000 000000  000000 000000
000000 000000
// full scale into large coefficients clips both ways
0 4
7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff
7fffff 800000
7fffff 800000
800000 7fffff
800000 7fffff
// new set written at run time
0 4
2000 4000 0000 0000 0000 0000 0000 e000
100000 f00000
345678 0abcde
fedcba 012345
000800 ff8000
ff

// ==== compile.f ====
common/audio_pkg.sv
common/pcm_if.sv
fir/coef_bank.sv
fir/fir_stereo.sv
i2s/i2s_rx.sv
i2s/i2s_tx.sv
logic/audio_processor.sv
testbench/tb_audio_processor.sv

// ==== Bender.yml ====
package:
  name: audio_processor

sources:
  - files:
      - common/audio_pkg.sv
      - common/pcm_if.sv
      - fir/coef_bank.sv
      - fir/fir_stereo.sv
      - i2s/i2s_rx.sv
      - i2s/i2s_tx.sv
      - logic/audio_processor.sv
  - target: test
    files:
      - testbench/tb_audio_processor.sv

// ==== testbench/tb_audio_processor.sv ====
`timescale 1ns/1ps

module tb_audio_processor;
    import audio_pkg::*;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  bypass;
    logic                  i2s_bclk;
    logic                  i2s_lrclk;
    logic                  i2s_d;
    logic                  coef_we;
    logic [tap_addr_w-1:0] coef_waddr;
    coef_t                 coef_wdata;
    logic                  dac_rst;
    logic                  dac_bclk;
    logic                  dac_lrclk;
    logic                  dac_data;
    logic                  overrun;

    logic [31:0]        stim_mem [128];     // words of the stim file
    logic signed [15:0] coefs [num_taps];   // set of the running section
    logic signed [23:0] hist_l [num_taps];  // model delay lines with [0] newest
    logic signed [23:0] hist_r [num_taps];
    logic               bypass_now;
    logic               exp_started = 1'b0; // first non-zero expected pair seen
    logic               out_started = 1'b0; // first non-zero dac pair seen
    logic [47:0]        exp_q [$];          // {left, right} waiting for the dac
    int                 errors = 0;
    int                 ptr;
    int                 npairs;
    int                 gap;
    int                 total_frames;

    // i2s decoder state
    logic               bclk_prev = 1'b0;
    logic               ws_prev = 1'b0;
    int                 pos = 100;          // ignore bits until the first slot edge
    logic [23:0]        dec_l = '0;
    logic [23:0]        dec_r = '0;

    audio_processor dut (.*);

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] got);
        if (got !== expected) begin
            errors++;
            $display("Error at %0d ns: %s expected %h got %h", $time, name, expected, got);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    ////////////////////
    // i2s source
    task automatic bit_period(input logic ws, input logic d);
        @(posedge clk);
        i2s_bclk  <= 1'b0;                  // data and ws move on the falling edge
        i2s_lrclk <= ws;
        i2s_d     <= d;
        repeat (3) @(posedge clk);
        @(posedge clk);
        i2s_bclk  <= 1'b1;
        repeat (3) @(posedge clk);
    endtask

    task automatic send_frame(input logic [23:0] l, input logic [23:0] r);
        logic [23:0] word;
        int          j;
        for (int i = 0; i < 64; i++) begin
            j    = i % 32;
            word = (i < 32) ? l : r;
            bit_period(i >= 32, (j >= 1 && j <= 24) ? word[24 - j] : 1'b0);  // one bit delay
        end
    endtask

    // sum of coef[k] * x[n-k] shifted by 15 and clipped to 24 bits
    function automatic logic [23:0] filter_rule(input logic right_ch);
        longint acc;
        acc = 0;
        for (int k = 0; k < num_taps; k++)
            acc += longint'(coefs[k]) * longint'(right_ch ? hist_r[k] : hist_l[k]);
        acc = acc >>> 15;
        if (acc > 64'sd8388607)
            return 24'h7fffff;
        else if (acc < -64'sd8388608)
            return 24'h800000;
        return acc[23:0];
    endfunction

    task automatic drive_pair(input logic [23:0] l, input logic [23:0] r);
        logic [23:0] exp_l;
        logic [23:0] exp_r;
        for (int k = num_taps - 1; k > 0; k--) begin
            hist_l[k] = hist_l[k-1];
            hist_r[k] = hist_r[k-1];
        end
        hist_l[0] = l;
        hist_r[0] = r;
        exp_l = bypass_now ? l : filter_rule(1'b0);
        exp_r = bypass_now ? r : filter_rule(1'b1);
        if (exp_l != '0 || exp_r != '0)
            exp_started = 1'b1;
        if (exp_started)
            exp_q.push_back({exp_l, exp_r});
        send_frame(l, r);
    endtask

    task automatic load_coefs(input logic byp);
        for (int k = 0; k < num_taps; k++) begin
            @(posedge clk);
            coef_we    <= 1'b1;
            coef_waddr <= tap_addr_w'(k);
            coef_wdata <= coefs[k];
            if (k == 0)
                bypass <= byp;
        end
        @(posedge clk);
        coef_we <= 1'b0;
    endtask

    task automatic watchdog(input int frames);
        realtime limit;
        limit = (frames + 6) * 512 * 20.0;  // frames of 512 clk at 20 ns
        #(limit);
        $display("Timeout: dac output stream not complete after %0d ns", $time);
        $display("TEST FAILED");
        $fatal(1, "run stopped by the watchdog");
    endtask

    ////////////////////
    // dac monitor
    task automatic take_pair(input logic [23:0] l, input logic [23:0] r);
        logic [47:0] exp_pair;
        if (l != '0 || r != '0)
            out_started = 1'b1;             // leading silence is skipped
        if (out_started && exp_q.size() != 0) begin
            exp_pair = exp_q.pop_front();
            check_value("dac_data left", exp_pair[47:24], l);
            check_value("dac_data right", exp_pair[23:0], r);
            check_value("overrun", 32'd0, overrun);
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && dac_bclk && !bclk_prev) begin
            if (dac_lrclk != ws_prev) begin
                if (!dac_lrclk)
                    take_pair(dec_l, dec_r);    // frame complete after the right slot
                pos     = 0;                    // delay bit
                ws_prev = dac_lrclk;
            end else begin
                pos++;
                if (pos >= 1 && pos <= 24) begin
                    if (dac_lrclk)
                        dec_r = {dec_r[22:0], dac_data};
                    else
                        dec_l = {dec_l[22:0], dac_data};
                end
            end
        end
        bclk_prev = dac_bclk;
    end

    ////////////////////
    // main sequence
    initial begin
        rst_n      = 1'b0;
        bypass     = 1'b0;
        i2s_bclk   = 1'b0;
        i2s_lrclk  = 1'b1;                  // idle as the end of a right slot
        i2s_d      = 1'b0;
        coef_we    = 1'b0;
        coef_waddr = '0;
        coef_wdata = '0;
        for (int k = 0; k < num_taps; k++) begin
            hist_l[k] = '0;
            hist_r[k] = '0;
        end
        void'($urandom(32'h569e));
        $readmemh("testbench/audio_stim.txt", stim_mem);

        ptr          = 0;
        total_frames = 0;
        while (stim_mem[ptr] == 32'h0 || stim_mem[ptr] == 32'h1) begin
            total_frames += num_taps + stim_mem[ptr+1];     // flush plus pairs
            ptr          += 10 + 2 * stim_mem[ptr+1];
        end
        if (total_frames == 0) begin
            $display("The stim file could not be read or holds no sections");
            $display("TEST FAILED");
            $fatal(1, "no stimulus");
        end
        fork
            watchdog(total_frames);
        join_none

        repeat (8) @(posedge clk);
        check_value("dac_rst", 32'd1, dac_rst);
        check_value("dac_bclk", 32'd0, dac_bclk);
        check_value("dac_lrclk", 32'd0, dac_lrclk);
        check_value("dac_data", 32'd0, dac_data);
        check_value("overrun", 32'd0, overrun);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("dac_rst", 32'd0, dac_rst);

        repeat (2) bit_period(1'b1, 1'b0);  // gives the rx a slot edge to lock on
        @(posedge dac_lrclk);               // pairs then land mid dac frame

        ptr = 0;
        while (stim_mem[ptr] == 32'h0 || stim_mem[ptr] == 32'h1) begin
            bypass_now = stim_mem[ptr][0];
            npairs     = stim_mem[ptr+1];
            for (int k = 0; k < num_taps; k++)
                coefs[k] = stim_mem[ptr+2+k][15:0];
            ptr += 10;
            gap  = $urandom % 4;
            repeat (gap) @(posedge clk);
            fork
                load_coefs(bypass_now);
                repeat (num_taps) drive_pair('0, '0);   // flush the delay lines
            join
            for (int p = 0; p < npairs; p++) begin
                drive_pair(stim_mem[ptr][23:0], stim_mem[ptr+1][23:0]);
                ptr += 2;
            end
        end

        while (exp_q.size() != 0)
            @(posedge clk);
        check_value("overrun", 32'd0, overrun);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/audio_processor.sv ====
`timescale 1ns/1ps

module audio_processor (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             bypass,
    input  logic                             i2s_bclk,
    input  logic                             i2s_lrclk,
    input  logic                             i2s_d,
    input  logic                             coef_we,
    input  logic [audio_pkg::tap_addr_w-1:0] coef_waddr,
    input  audio_pkg::coef_t                 coef_wdata,
    output logic                             dac_rst,
    output logic                             dac_bclk,
    output logic                             dac_lrclk,
    output logic                             dac_data,
    output logic                             overrun
);
    import audio_pkg::*;

    logic [tap_addr_w-1:0] coef_raddr;      // driven by the filter sequencer
    coef_t                 coef_rdata;

    pcm_if rx_pcm ();                       // receiver to filter
    pcm_if fir_pcm ();                      // filter to transmitter

    assign dac_rst = ~rst_n;                // dac held while the system is in reset

    i2s_rx u_i2s_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .i2s_bclk  (i2s_bclk),
        .i2s_lrclk (i2s_lrclk),
        .i2s_d     (i2s_d),
        .overrun   (overrun),
        .pcm       (rx_pcm.src)
    );

    coef_bank u_coef_bank (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (coef_we),
        .waddr (coef_waddr),
        .wdata (coef_wdata),
        .raddr (coef_raddr),
        .rdata (coef_rdata)
    );

    fir_stereo u_fir_stereo (
        .clk        (clk),
        .rst_n      (rst_n),
        .bypass     (bypass),
        .coef_rdata (coef_rdata),
        .coef_raddr (coef_raddr),
        .in_pcm     (rx_pcm.dst),
        .out_pcm    (fir_pcm.src)
    );

    i2s_tx u_i2s_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .dac_bclk  (dac_bclk),
        .dac_lrclk (dac_lrclk),
        .dac_data  (dac_data),
        .pcm       (fir_pcm.dst)
    );

endmodule

// ==== i2s/i2s_tx.sv ====
`timescale 1ns/1ps

module i2s_tx (
    input  logic clk,
    input  logic rst_n,
    output logic dac_bclk,
    output logic dac_lrclk,
    output logic dac_data,
    pcm_if.dst   pcm
);
    import audio_pkg::*;

    logic [bclk_div_w-1:0]  div_cnt;
    logic                   bclk_fall;      // bclk goes low this cycle
    logic [frame_cnt_w-1:0] bit_cnt;        // bclk periods into the frame
    logic [frame_cnt_w-1:0] bit_nxt;
    logic [slot_cnt_w-1:0]  slot_pos;       // position of the next bit in its slot
    logic                   take;           // accept a pair at frame start
    sample_t                cur_l;          // pair of the current frame
    sample_t                cur_r;
    sample_t                next_l;
    sample_t                sr;             // msb first shifter

    assign bclk_fall = dac_bclk && (div_cnt == bclk_div_w'(bclk_half - 1));
    assign bit_nxt   = bit_cnt + 1'b1;
    assign slot_pos  = bit_nxt[slot_cnt_w-1:0];
    assign take      = bclk_fall && (bit_nxt == '0) && pcm.req && !pcm.ack;
    assign next_l    = take ? pcm.left : cur_l;

    ////////////////////
    // bit clock divider
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt  <= '0;
            dac_bclk <= 1'b0;
        end else if (div_cnt == bclk_div_w'(bclk_half - 1)) begin
            div_cnt  <= '0;
            dac_bclk <= ~dac_bclk;
        end else begin
            div_cnt  <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt   <= '1;                    // first fall opens a frame
            dac_lrclk <= 1'b0;
            dac_data  <= 1'b0;
            cur_l     <= '0;                    // zeros until the first pair
            cur_r     <= '0;
            sr        <= '0;
            pcm.ack   <= 1'b0;
        end else begin
            if (take) begin
                cur_l   <= pcm.left;
                cur_r   <= pcm.right;
                pcm.ack <= 1'b1;
            end else if (pcm.ack && !pcm.req) begin
                pcm.ack <= 1'b0;
            end

            if (bclk_fall) begin
                bit_cnt   <= bit_nxt;
                dac_lrclk <= bit_nxt[frame_cnt_w-1];    // high in right slot
                if (slot_pos == '0) begin
                    sr       <= bit_nxt[frame_cnt_w-1] ? cur_r : next_l;
                    dac_data <= 1'b0;                   // padding of the old slot
                end else if (slot_pos <= slot_cnt_w'(sample_w)) begin
                    dac_data <= sr[sample_w-1];
                    sr       <= sr << 1;
                end else begin
                    dac_data <= 1'b0;                   // bits 25 to 32
                end
            end
        end
    end

endmodule

// ==== i2s/i2s_rx.sv ====
`timescale 1ns/1ps

module i2s_rx (
    input  logic clk,
    input  logic rst_n,
    input  logic i2s_bclk,
    input  logic i2s_lrclk,
    input  logic i2s_d,
    output logic overrun,
    pcm_if.src   pcm
);
    import audio_pkg::*;

    logic [1:0]            bclk_sync;       // two-flop synchronizers
    logic [1:0]            lrclk_sync;
    logic [1:0]            d_sync;
    logic                  bclk_q;          // for rising edge detect
    logic                  bclk_rise;
    logic                  ws_q;            // channel of the previous bit
    logic                  slot_edge;       // lrclk changed since the last bit
    logic                  take_bit;        // one of the 24 data bits
    logic                  word_done;       // lsb of the right channel
    logic [slot_cnt_w-1:0] bit_cnt;         // data bits taken in this slot
    sample_t               left_sr;
    sample_t               right_sr;

    ////////////////////
    // pin synchronizers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bclk_sync  <= '0;
            lrclk_sync <= '0;
            d_sync     <= '0;
            bclk_q     <= 1'b0;
        end else begin
            bclk_sync  <= {bclk_sync[0], i2s_bclk};
            lrclk_sync <= {lrclk_sync[0], i2s_lrclk};
            d_sync     <= {d_sync[0], i2s_d};
            bclk_q     <= bclk_sync[1];
        end
    end

    assign bclk_rise = bclk_sync[1] & ~bclk_q;
    assign slot_edge = lrclk_sync[1] != ws_q;
    assign take_bit  = bclk_rise && !slot_edge && (bit_cnt != slot_cnt_w'(sample_w));
    assign word_done = take_bit && ws_q && (bit_cnt == slot_cnt_w'(sample_w - 1));

    ////////////////////
    // slot bit counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ws_q    <= 1'b0;
            bit_cnt <= slot_cnt_w'(sample_w);   // wait for a slot edge
        end else if (bclk_rise) begin
            ws_q <= lrclk_sync[1];
            if (slot_edge)
                bit_cnt <= '0;                  // delay bit, msb follows
            else if (take_bit)
                bit_cnt <= bit_cnt + 1'b1;      // holds after bit 24
        end
    end

    always_ff @(posedge clk) begin
        if (take_bit) begin
            if (ws_q)
                right_sr <= {right_sr[sample_w-2:0], d_sync[1]};
            else
                left_sr  <= {left_sr[sample_w-2:0], d_sync[1]};
        end
        if (word_done && !pcm.req && !pcm.ack) begin
            pcm.left  <= left_sr;
            pcm.right <= {right_sr[sample_w-2:0], d_sync[1]};  // last bit joins here
        end
    end

    ////////////////////
    // four-phase source
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcm.req <= 1'b0;
            overrun <= 1'b0;
        end else if (word_done) begin
            if (pcm.req || pcm.ack)
                overrun <= 1'b1;                // pair dropped, sticky
            else
                pcm.req <= 1'b1;
        end else if (pcm.req && pcm.ack) begin
            pcm.req <= 1'b0;
        end
    end

endmodule

// ==== fir/fir_stereo.sv ====
`timescale 1ns/1ps

module fir_stereo (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             bypass,
    input  audio_pkg::coef_t                 coef_rdata,
    output logic [audio_pkg::tap_addr_w-1:0] coef_raddr,
    pcm_if.dst                               in_pcm,
    pcm_if.src                               out_pcm
);
    import audio_pkg::*;

    sample_t                 x_l [num_taps];    // x_l[k] is x[n-k]
    sample_t                 x_r [num_taps];
    logic signed [acc_w-1:0] acc_l;
    logic signed [acc_w-1:0] acc_r;
    logic                    run;               // mac sequence active
    logic                    fin;               // saturation cycle
    logic [step_w-1:0]       step;              // 0 is the first fetch
    logic [tap_addr_w-1:0]   mac_idx;           // tap of the coef on coef_rdata
    logic                    accept;

    // shift out the fraction and clip to the sample range
    function automatic sample_t sat(input logic signed [acc_w-1:0] acc);
        logic signed [acc_w-1:0] shifted;
        shifted = acc >>> frac_bits;
        if (shifted > sample_max)
            return sample_max;
        if (shifted < sample_min)
            return sample_min;
        return shifted[sample_w-1:0];
    endfunction

    assign mac_idx = tap_addr_w'(step - 1'b1);
    assign accept  = !run && !fin && in_pcm.req && !in_pcm.ack
                     && !out_pcm.req && !out_pcm.ack;  // hold input under back-pressure

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_taps; i++) begin
                x_l[i] <= '0;
                x_r[i] <= '0;
            end
            acc_l         <= '0;
            acc_r         <= '0;
            run           <= 1'b0;
            fin           <= 1'b0;
            step          <= '0;
            coef_raddr    <= '0;
            in_pcm.ack    <= 1'b0;
            out_pcm.req   <= 1'b0;
            out_pcm.left  <= '0;
            out_pcm.right <= '0;
        end else begin
            ////////////////////
            // input side, delay line shift
            if (accept) begin
                x_l[0] <= in_pcm.left;
                x_r[0] <= in_pcm.right;
                for (int i = 1; i < num_taps; i++) begin
                    x_l[i] <= x_l[i-1];
                    x_r[i] <= x_r[i-1];
                end
                in_pcm.ack <= 1'b1;
                run        <= 1'b1;
                step       <= '0;
                coef_raddr <= '0;
                acc_l      <= '0;
                acc_r      <= '0;
            end else if (in_pcm.ack && !in_pcm.req) begin
                in_pcm.ack <= 1'b0;
            end

            ////////////////////
            // multiply-accumulate, one tap per cycle
            if (run) begin
                coef_raddr <= coef_raddr + 1'b1;    // wraps after the last tap
                step       <= step + 1'b1;
                if (step != '0) begin
                    acc_l <= acc_l + coef_rdata * x_l[mac_idx];
                    acc_r <= acc_r + coef_rdata * x_r[mac_idx];
                end
                if (step == step_w'(num_taps)) begin
                    run <= 1'b0;
                    fin <= 1'b1;
                end
            end

            ////////////////////
            // output side
            if (fin) begin
                fin           <= 1'b0;
                out_pcm.req   <= 1'b1;
                out_pcm.left  <= bypass ? x_l[0] : sat(acc_l);  // x_l[0] is the raw input
                out_pcm.right <= bypass ? x_r[0] : sat(acc_r);
            end else if (out_pcm.req && out_pcm.ack) begin
                out_pcm.req <= 1'b0;
            end
        end
    end

endmodule

// ==== fir/coef_bank.sv ====
`timescale 1ns/1ps

module coef_bank (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            we,
    input  logic [audio_pkg::tap_addr_w-1:0] waddr,
    input  audio_pkg::coef_t                wdata,
    input  logic [audio_pkg::tap_addr_w-1:0] raddr,
    output audio_pkg::coef_t                rdata
);
    import audio_pkg::*;

    coef_t coef_q [num_taps];           // one word per tap, shared by both channels

    ////////////////////
    // write port and registered read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_taps; i++) begin
                coef_q[i] <= '0;        // filter mutes until loaded
            end
            rdata <= '0;
        end else begin
            if (we)
                coef_q[waddr] <= wdata;
            rdata <= coef_q[raddr];     // valid one cycle after raddr
        end
    end

endmodule

// ==== common/pcm_if.sv ====
`timescale 1ns/1ps

interface pcm_if;
    import audio_pkg::*;

    logic    req;       // pair on left/right is valid
    logic    ack;       // pair taken by the sink
    sample_t left;
    sample_t right;

    // producer side
    modport src (
        output req,
        output left,
        output right,
        input  ack
    );

    // consumer side
    modport dst (
        input  req,
        input  left,
        input  right,
        output ack
    );

endinterface

// ==== common/audio_pkg.sv ====
package audio_pkg;

    ////////////////////
    // pcm and filter formats
    localparam int sample_w   = 24;                     // pcm sample bits
    localparam int coef_w     = 16;                     // q1.15 coefficient
    localparam int acc_w      = 48;                     // mac accumulator
    localparam int frac_bits  = 15;                     // acc shift before saturation
    localparam int num_taps   = 8;
    localparam int tap_addr_w = 3;                      // coef address bits
    localparam int step_w     = $clog2(num_taps + 1);   // fir sequencer count

    typedef logic signed [sample_w-1:0] sample_t;
    typedef logic signed [coef_w-1:0]   coef_t;

    localparam sample_t sample_max = {1'b0, {(sample_w - 1){1'b1}}};  // clip high
    localparam sample_t sample_min = {1'b1, {(sample_w - 1){1'b0}}};  // clip low

    ////////////////////
    // i2s framing
    localparam int bits_per_slot = 32;                  // bclk periods per channel
    localparam int slot_cnt_w    = $clog2(bits_per_slot);
    localparam int frame_cnt_w   = slot_cnt_w + 1;      // two slots per frame
    localparam int bclk_half     = 4;                   // clk cycles per bclk half
    localparam int bclk_div_w    = $clog2(bclk_half);

endpackage
